/* files.f */
+incdir+verilog
verilog/gfx_pkg.sv
verilog/gfx_memory_arbiter.sv
verilog/gfx_vram_bank.sv
verilog/gfx_memory_top.sv
verification/gfx_memory_checker.sv
verification/gfx_memory_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	-f files.f \
	--top-module gfx_memory_tb \
	-o gfx_memory_sim

./obj_dir/gfx_memory_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

/* verification/gfx_memory_tb.sv */
`include "gfx_consts.svh"

module gfx_memory_tb
	import gfx_pkg::*;
();

	localparam int NC = `GFX_NUM_CLIENTS;

	typedef struct packed {
		logic [8*16-1:0]                          name;
		logic [NC-1:0]                            mask;   // clients taking part
		logic [NC-1:0][`GFX_ADDR_W-1:0]           addr;
		logic [NC-1:0][3:0]                       delay;  // cycles after entry start
		logic                                     ordered;
		logic                                     lat_two;
		logic [NC-1:0][`GFX_CLIENT_ID_W-1:0]      order;  // expected completion sequence
		logic [2:0]                               count;
		logic                                     wr_en;
		logic [3:0]                               wr_cycle;
		gfx_addr_t                                wr_addr;
		gfx_data_t                                wr_data;
	} entry_t;

	logic         clk;
	logic         rst_n;
	gfx_rd_req_t  req [NC];
	gfx_rd_rsp_t  rsp [NC];
	gfx_wr_t      wr;
	entry_t       cur;
	logic         test_open;
	int           chk_errors;
	entry_t       tbl [$];
	int           n_writes;
	int           limit = 0;
	int           cycle = 0;

	gfx_memory_top gfx_memory_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.sprite_req (req[0]),
		.bg0_req    (req[1]),
		.bg1_req    (req[2]),
		.bg2_req    (req[3]),
		.ov_req     (req[4]),
		.sprite_rsp (rsp[0]),
		.bg0_rsp    (rsp[1]),
		.bg1_rsp    (rsp[2]),
		.bg2_rsp    (rsp[3]),
		.ov_rsp     (rsp[4]),
		.wr         (wr)
	);

	gfx_memory_checker gfx_memory_checker_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.wr        (wr),
		.test_name (cur.name),
		.test_open (test_open),
		.ordered   (cur.ordered),
		.lat_two   (cur.lat_two),
		.exp_order (cur.order),
		.exp_count (cur.count),
		.errors    (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (limit != 0 && cycle >= limit) begin
			$display("run did not finish before the cycle limit");
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [`GFX_ADDR_W-1:0] bank_addr(input int b, input int off);
		return {b[1:0], off[`GFX_BANK_ADDR_W-1:0]};
	endfunction

	function automatic entry_t blank_entry(input string nm, input logic ordered,
		input logic lat_two, input int count);
		entry_t          e;
		logic [8*16-1:0] nb;
		$sformat(nb, "%s", nm);
		e = '0;
		e.name = nb;
		e.ordered = ordered;
		e.lat_two = lat_two;
		e.count = 3'(count);
		return e;
	endfunction

	task automatic build_table(input gfx_addr_t rnd_addr);
		entry_t e;
		for (int c = 0; c < NC; c++) begin
			for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
				e = blank_entry($sformatf("solo_c%0d_b%0d", c, b), 1'b1, 1'b1, 1);
				e.mask[c] = 1'b1;
				e.addr[c] = bank_addr(b, 16'h0100 + c * 16'h0321 + b);
				e.order[0] = c[2:0];
				tbl.push_back(e);
			end
		end
		e = blank_entry("all_same_bank", 1'b1, 1'b0, 5);
		e.mask = '1;
		for (int c = 0; c < NC; c++) begin
			e.addr[c] = bank_addr(2, 16'h2000 + c * 7);
			e.order[c] = c[2:0];
		end
		tbl.push_back(e);
		e = blank_entry("four_banks", 1'b0, 1'b1, 4);
		e.mask = 5'b11110;
		for (int c = 1; c < NC; c++) begin
			e.addr[c] = bank_addr(4 - c, 16'h0a00 + c);
		end
		tbl.push_back(e);
		e = blank_entry("grant_hold", 1'b1, 1'b0, 2);
		e.mask = 5'b01001;
		e.addr[3] = bank_addr(1, 16'h0333);
		e.addr[0] = bank_addr(1, 16'h0444);
		e.delay[0] = 4'd1;  // sprite arrives after bg2 holds the bank
		e.order[0] = 3'd3;
		e.order[1] = 3'd0;
		tbl.push_back(e);
		e = blank_entry("write_then_read", 1'b1, 1'b1, 1);
		e.mask = 5'b00100;
		e.addr[2] = bank_addr(2, 16'h0555);
		e.delay[2] = 4'd1;
		e.order[0] = 3'd2;
		e.wr_en = 1'b1;
		e.wr_addr = e.addr[2];
		e.wr_data = 16'h5aa5;
		tbl.push_back(e);
		e = blank_entry("write_other_bank", 1'b1, 1'b1, 1);
		e.mask = 5'b10000;
		e.addr[4] = bank_addr(0, 16'h0666);
		e.order[0] = 3'd4;
		e.wr_en = 1'b1;
		e.wr_cycle = 4'd1;  // lands while bank 0 takes the read
		e.wr_addr = bank_addr(3, 16'h0666);
		e.wr_data = 16'h0ff0;
		tbl.push_back(e);
		e = blank_entry("write_at_ready", 1'b1, 1'b1, 1);
		e.mask = 5'b00010;
		e.addr[1] = bank_addr(1, 16'h0777);
		e.order[0] = 3'd1;
		e.wr_en = 1'b1;
		e.wr_cycle = 4'd2;  // old word already in the read register
		e.wr_addr = e.addr[1];
		e.wr_data = 16'hc33c;
		tbl.push_back(e);
		e = blank_entry("random_addr", 1'b1, 1'b1, 1);
		e.mask = 5'b00001;
		e.addr[0] = rnd_addr;
		tbl.push_back(e);
	endtask

	function automatic int count_writes();
		int n;
		n = 0;
		foreach (tbl[i]) begin
			n += $countones(tbl[i].mask) + int'(tbl[i].wr_en);
		end
		return n;
	endfunction

	task automatic write_word(input gfx_addr_t a, input gfx_data_t d);
		wr.strobe = 1'b1;
		wr.addr = a;
		wr.data = d;
		@(posedge clk);
		#1;
		wr = '0;
	endtask

	task automatic load_memory();
		foreach (tbl[i]) begin
			for (int c = 0; c < NC; c++) begin
				if (tbl[i].mask[c]) begin
					write_word(tbl[i].addr[c], tbl[i].addr[c] ^ 16'ha5c3);
				end
			end
		end
	endtask

	task automatic run_entry(input entry_t e);
		logic [NC-1:0] issued;
		logic [NC-1:0] done;
		int            k;
		issued = '0;
		done = '0;
		k = 0;
		cur = e;
		test_open = 1'b1;
		while (done != e.mask || (e.wr_en && k <= int'(e.wr_cycle))) begin
			for (int c = 0; c < NC; c++) begin
				if (e.mask[c] && !issued[c] && k == int'(e.delay[c])) begin
					req[c].valid = 1'b1;
					req[c].addr = e.addr[c];
					issued[c] = 1'b1;
				end
			end
			if (e.wr_en && k == int'(e.wr_cycle)) begin
				wr.strobe = 1'b1;
				wr.addr = e.wr_addr;
				wr.data = e.wr_data;
			end
			@(posedge clk);
			for (int c = 0; c < NC; c++) begin
				if (issued[c] && rsp[c].ready) begin
					done[c] = 1'b1;
				end
			end
			#1;
			wr = '0;
			for (int c = 0; c < NC; c++) begin
				if (done[c]) begin
					req[c] = '0;  // held until its ready only
				end
			end
			k++;
		end
		repeat (2) @(posedge clk);
		#1;
		test_open = 1'b0;
		@(posedge clk);
		#1;
	endtask

	initial begin
		gfx_addr_t rnd_addr;
		rst_n = 1'b0;
		wr = '0;
		cur = '0;
		test_open = 1'b0;
		for (int c = 0; c < NC; c++) begin
			req[c] = '0;
		end
		void'($urandom(32'h1d89));
		rnd_addr = gfx_addr_t'($urandom());
		build_table(rnd_addr);
		n_writes = count_writes();
		limit = tbl.size() * 40 + n_writes * 4 + 10;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge clk);  // quiet bus before the first request
		#1;
		load_memory();
		foreach (tbl[i]) begin
			run_entry(tbl[i]);
		end
		$display("%0d tests, %0d writes, %0d errors", tbl.size(), n_writes, chk_errors);
		if (chk_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verification/gfx_memory_checker.sv */
`include "gfx_consts.svh"

module gfx_memory_checker
	import gfx_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  gfx_rd_req_t      req [`GFX_NUM_CLIENTS],
	input  gfx_rd_rsp_t      rsp [`GFX_NUM_CLIENTS],
	input  gfx_wr_t          wr,
	input  logic [8*16-1:0]  test_name,
	input  logic             test_open,
	input  logic             ordered,
	input  logic             lat_two,
	input  logic [`GFX_NUM_CLIENTS-1:0][`GFX_CLIENT_ID_W-1:0] exp_order,
	input  logic [2:0]       exp_count,
	output int               errors
);

	localparam int NC = `GFX_NUM_CLIENTS;

	gfx_data_t      model [gfx_addr_t];  // only words seen on the write port
	logic [NC-1:0]  pending = '0;
	int             start [NC];          // cycle where valid was first seen
	int             cyc = 0;
	int             done_cnt = 0;
	int             err_cnt = 0;
	logic           open_q = 1'b0;

	assign errors = err_cnt;

	task automatic complete(input int c);
		gfx_addr_t a;
		a = req[c].addr;
		if (!model.exists(a)) begin
			err_cnt++;
			$display("client %0d read address %h that was never written", c, a);
		end else if (rsp[c].data !== model[a]) begin
			err_cnt++;
			$display("Error %0s expected %h actual %h (data, client %0d)",
				test_name, model[a], rsp[c].data, c);
		end
		if (lat_two && (cyc - start[c]) != 2) begin
			err_cnt++;
			$display("Error %0s expected %0d actual %0d (latency, client %0d)",
				test_name, 2, cyc - start[c], c);
		end
		if (test_open) begin
			if (done_cnt >= int'(exp_count)) begin
				err_cnt++;
				$display("%0s: client %0d completed a read that was not expected", test_name, c);
			end else if (ordered && exp_order[done_cnt] != c[2:0]) begin
				err_cnt++;
				$display("Error %0s expected %0d actual %0d (completion order)",
					test_name, exp_order[done_cnt], c);
			end
			done_cnt++;
		end
	endtask

	always @(posedge clk) begin
		int n_ready;
		n_ready = 0;
		if (rst_n) begin
			cyc++;
			if (test_open && !open_q) begin
				done_cnt = 0;
			end
			for (int c = 0; c < NC; c++) begin
				if (req[c].valid && !pending[c]) begin
					pending[c] = 1'b1;
					start[c] = cyc;
				end
				if (rsp[c].ready !== 1'b0) begin
					if (!req[c].valid) begin
						err_cnt++;
						$display("client %0d raised ready with no request pending", c);
					end else begin
						complete(c);
						pending[c] = 1'b0;
						n_ready++;
					end
				end
			end
			if (ordered && test_open && n_ready > 1) begin
				err_cnt++;
				$display("%0s: %0d readies in one cycle, expected one at a time",
					test_name, n_ready);
			end
			if (!test_open && open_q && done_cnt != int'(exp_count)) begin
				err_cnt++;
				$display("Error %0s expected %0d actual %0d (completions)",
					test_name, exp_count, done_cnt);
			end
			open_q = test_open;
			// reads above saw the memory before this write
			if (wr.strobe) begin
				model[wr.addr] = wr.data;
			end
		end
	end

endmodule

/* verilog/gfx_memory_top.sv */
`include "gfx_consts.svh"

module gfx_memory_top
	import gfx_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  gfx_rd_req_t  sprite_req,
	input  gfx_rd_req_t  bg0_req,
	input  gfx_rd_req_t  bg1_req,
	input  gfx_rd_req_t  bg2_req,
	input  gfx_rd_req_t  ov_req,

	output gfx_rd_rsp_t  sprite_rsp,
	output gfx_rd_rsp_t  bg0_rsp,
	output gfx_rd_rsp_t  bg1_rsp,
	output gfx_rd_rsp_t  bg2_rsp,
	output gfx_rd_rsp_t  ov_rsp,

	input  gfx_wr_t      wr
);

	gfx_rd_req_t    client_req [`GFX_NUM_CLIENTS];
	gfx_rd_rsp_t    client_rsp [`GFX_NUM_CLIENTS];
	gfx_bank_req_t  bank_req [`GFX_NUM_BANKS];
	gfx_bank_rsp_t  bank_rsp [`GFX_NUM_BANKS];

	gfx_bank_sel_t            wr_bank;
	gfx_bank_addr_t           wr_addr;
	logic [`GFX_NUM_BANKS-1:0] wr_strobe;

	// array index is the priority, sprite first
	assign client_req[0] = sprite_req;
	assign client_req[1] = bg0_req;
	assign client_req[2] = bg1_req;
	assign client_req[3] = bg2_req;
	assign client_req[4] = ov_req;

	assign sprite_rsp = client_rsp[0];
	assign bg0_rsp    = client_rsp[1];
	assign bg1_rsp    = client_rsp[2];
	assign bg2_rsp    = client_rsp[3];
	assign ov_rsp     = client_rsp[4];

	// write decode by addr 15:14
	assign wr_bank = wr.addr[`GFX_ADDR_W-1 -: $bits(gfx_bank_sel_t)];
	assign wr_addr = wr.addr[`GFX_BANK_ADDR_W-1:0];

	gfx_memory_arbiter gfx_memory_arbiter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.client_req (client_req),
		.client_rsp (client_rsp),
		.bank_req   (bank_req),
		.bank_rsp   (bank_rsp)
	);

	for (genvar b = 0; b < `GFX_NUM_BANKS; b++) begin : g_bank
		assign wr_strobe[b] = wr.strobe && (wr_bank == gfx_bank_sel_t'(b));

		gfx_vram_bank bank_i (
			.clk       (clk),
			.rst_n     (rst_n),
			.req       (bank_req[b]),
			.rsp       (bank_rsp[b]),
			.wr_strobe (wr_strobe[b]),
			.wr_addr   (wr_addr),
			.wr_data   (wr.data)
		);
	end

endmodule

/* verilog/gfx_vram_bank.sv */
`include "gfx_consts.svh"

module gfx_vram_bank
	import gfx_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,

	input  gfx_bank_req_t   req,
	output gfx_bank_rsp_t   rsp,

	input  logic            wr_strobe,
	input  gfx_bank_addr_t  wr_addr,
	input  gfx_data_t       wr_data
);

	localparam int DEPTH = 1 << `GFX_BANK_ADDR_W;

	gfx_data_t        mem [0:DEPTH-1];
	gfx_data_t        rd_data;
	gfx_bank_state_t  state;
	gfx_bank_state_t  state_next;
	logic             rd_accept;

	// a write in the same cycle pushes the read out
	assign rd_accept = (state == bank_idle) && req.valid && !wr_strobe;

	always_ff @(posedge clk) begin
		if (wr_strobe) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rd_data <= mem[req.addr];  // registered read
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			bank_idle: begin
				if (rd_accept) begin
					state_next = bank_respond;
				end
			end
			bank_respond: begin
				state_next = bank_idle;  // ready is a single pulse
			end
			default: begin
				state_next = bank_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= bank_idle;
		end else begin
			state <= state_next;
		end
	end

	assign rsp.ready = (state == bank_respond);
	assign rsp.dout  = rd_data;

endmodule

/* verilog/gfx_memory_arbiter.sv */
`include "gfx_consts.svh"

module gfx_memory_arbiter
	import gfx_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,

	input  gfx_rd_req_t    client_req [`GFX_NUM_CLIENTS],
	output gfx_rd_rsp_t    client_rsp [`GFX_NUM_CLIENTS],

	output gfx_bank_req_t  bank_req [`GFX_NUM_BANKS],
	input  gfx_bank_rsp_t  bank_rsp [`GFX_NUM_BANKS]
);

	localparam int NC = `GFX_NUM_CLIENTS;
	localparam int NB = `GFX_NUM_BANKS;

	// bank selected by each client's address
	gfx_bank_sel_t   client_bank [NC];

	// per bank winner of this cycle
	logic [NB-1:0]   pick_valid;
	gfx_client_id_t  pick_id [NB];

	// held grants
	logic [NB-1:0]   grant_valid;
	gfx_client_id_t  grant_id [NB];
	logic [NB-1:0]   grant_load;

	always_comb begin
		for (int c = 0; c < NC; c++) begin
			client_bank[c] = client_req[c].addr[`GFX_ADDR_W-1 -: $bits(gfx_bank_sel_t)];
		end
	end

	// fixed priority, lowest client index wins
	always_comb begin
		for (int b = 0; b < NB; b++) begin
			pick_valid[b] = 1'b0;
			pick_id[b]    = '0;
			for (int c = NC - 1; c >= 0; c--) begin
				// the holder is still valid in its ready cycle, skip it
				if (client_req[c].valid &&
				    client_bank[c] == gfx_bank_sel_t'(b) &&
				    !(grant_valid[b] && grant_id[b] == gfx_client_id_t'(c))) begin
					pick_valid[b] = 1'b1;
					pick_id[b]    = gfx_client_id_t'(c);
				end
			end
		end
	end

	// a bank is free when nothing is held or the held read finishes now
	always_comb begin
		for (int b = 0; b < NB; b++) begin
			grant_load[b] = !grant_valid[b] || bank_rsp[b].ready;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_valid <= '0;
		end else begin
			for (int b = 0; b < NB; b++) begin
				if (grant_load[b]) begin
					grant_valid[b] <= pick_valid[b];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int b = 0; b < NB; b++) begin
			if (grant_load[b]) begin
				grant_id[b] <= pick_id[b];
			end
		end
	end

	// bank side follows the held grant only
	always_comb begin
		for (int b = 0; b < NB; b++) begin
			bank_req[b].valid = grant_valid[b];
			bank_req[b].addr  = client_req[grant_id[b]].addr[`GFX_BANK_ADDR_W-1:0];
		end
	end

	// route ready and data back to whoever holds the bank
	always_comb begin
		for (int c = 0; c < NC; c++) begin
			client_rsp[c].ready = 1'b0;
			client_rsp[c].data  = '0;
			for (int b = 0; b < NB; b++) begin
				if (grant_valid[b] && grant_id[b] == gfx_client_id_t'(c)) begin
					client_rsp[c].ready = bank_rsp[b].ready;
					client_rsp[c].data  = bank_rsp[b].dout;
				end
			end
		end
	end

endmodule

/* verilog/gfx_pkg.sv */
`include "gfx_consts.svh"

package gfx_pkg;

	typedef logic [`GFX_ADDR_W-1:0]             gfx_addr_t;
	typedef logic [`GFX_BANK_ADDR_W-1:0]        gfx_bank_addr_t;
	typedef logic [`GFX_DATA_W-1:0]             gfx_data_t;
	typedef logic [$clog2(`GFX_NUM_BANKS)-1:0]  gfx_bank_sel_t;

	// 0 sprite, 1..3 bg0..bg2, 4 overlay
	typedef logic [`GFX_CLIENT_ID_W-1:0]        gfx_client_id_t;

	// client read request, held until ready
	typedef struct packed {
		logic           valid;
		gfx_addr_t      addr;
	} gfx_rd_req_t;

	// client read response, ready lasts one cycle
	typedef struct packed {
		logic           ready;
		gfx_data_t      data;
	} gfx_rd_rsp_t;

	typedef struct packed {
		logic           valid;
		gfx_bank_addr_t addr;  // bank local word address
	} gfx_bank_req_t;

	typedef struct packed {
		logic           ready;
		gfx_data_t      dout;  // valid while ready
	} gfx_bank_rsp_t;

	// cpu side write, single cycle, never stalled
	typedef struct packed {
		logic           strobe;
		gfx_addr_t      addr;
		gfx_data_t      data;
	} gfx_wr_t;

	typedef enum logic {
		bank_idle,
		bank_respond
	} gfx_bank_state_t;

endpackage

/* verilog/gfx_consts.svh */
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// client side address, bank select in the top two bits
`define GFX_ADDR_W        16

// word address inside one bank
`define GFX_BANK_ADDR_W   14

// video word
`define GFX_DATA_W        16

// sprite, bg0, bg1, bg2, overlay
`define GFX_NUM_CLIENTS   5

// banks selected by addr 15:14
`define GFX_NUM_BANKS     4

// enough for all client indices
`define GFX_CLIENT_ID_W   3

`endif
